// ==== logic/l1_pkg.sv ====
package l1_pkg;

    // Core bus widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BE_W     = DATA_W / 8;          // One enable per byte lane

    // Cache geometry, one word per line
    localparam int NUM_SETS = 256;
    localparam int NUM_WAYS = 4;
    localparam int WAY_W    = $clog2(NUM_WAYS);

    // Address split  | tag 31:10 | index 9:2 | offset 1:0 |
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = $clog2(NUM_SETS);    // 8 bits
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;  // 22 bits

    // Replacement ages
    localparam int AGE_W    = 2;

    // Backing store, 64 KB of words
    localparam int RAM_WORDS = 16384;
    localparam int RAM_AW    = $clog2(RAM_WORDS);  // Uses addr 15:2

    typedef logic [WAY_W-1:0] way_t;
    typedef logic [AGE_W-1:0] age_t;

    localparam age_t AGE_MAX = age_t'(3);          // Saturation point

    // Legal access sizes
    localparam logic [BE_W-1:0] BE_BYTE = 4'b0001;
    localparam logic [BE_W-1:0] BE_HALF = 4'b0011;
    localparam logic [BE_W-1:0] BE_WORD = 4'b1111;

endpackage

// ==== logic/mem_port_if.sv ====
`timescale 1ns/10ps

// Cache to backing RAM link
// rd_data is combinational on addr, writes land on the next edge
interface mem_port_if ();

    logic [l1_pkg::ADDR_W-1:0] addr;       // Full byte address
    logic                      wr_en;      // Write-through strobe
    logic [l1_pkg::BE_W-1:0]   byte_mask;  // Lanes to write
    logic [l1_pkg::DATA_W-1:0] wr_data;    // Store data
    logic [l1_pkg::DATA_W-1:0] rd_data;    // Word at addr, pre-write

    // Cache side drives the request
    modport cache (
        output addr, wr_en, byte_mask, wr_data,
        input  rd_data
    );

    // RAM side answers with read data
    modport ram (
        input  addr, wr_en, byte_mask, wr_data,
        output rd_data
    );

endinterface

// ==== logic/way_age_tracker.sv ====
`timescale 1ns/10ps

// Saturating age counters per way per set
// Touched way drops to zero, all others in the set age by one
module way_age_tracker (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic [l1_pkg::INDEX_W-1:0] set_i,        // Set being looked at
    input  logic                       touch_i,      // Update ages of set_i
    input  l1_pkg::way_t               touch_way_i,  // Way just used
    output l1_pkg::way_t               victim_o      // Oldest way of set_i
);

    // Age storage
    l1_pkg::age_t ages_q [l1_pkg::NUM_SETS][l1_pkg::NUM_WAYS];

    l1_pkg::age_t max_age;  // Running maximum in victim search

    // Victim search over current set
    // Strict compare keeps the lowest index on a tie
    always_comb begin
        max_age  = ages_q[set_i][0];
        victim_o = '0;
        for (int w = 1; w < l1_pkg::NUM_WAYS; w++) begin
            if (ages_q[set_i][w] > max_age) begin
                max_age  = ages_q[set_i][w];
                victim_o = l1_pkg::way_t'(w);
            end
        end
    end

    // Age update
    always_ff @(posedge clk) begin
        if (reset_i) begin
            // All lines equally old after reset
            for (int s = 0; s < l1_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < l1_pkg::NUM_WAYS; w++) begin
                    ages_q[s][w] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int w = 0; w < l1_pkg::NUM_WAYS; w++) begin
                if (l1_pkg::way_t'(w) == touch_way_i) begin
                    ages_q[set_i][w] <= '0;                      // Most recent
                end else if (ages_q[set_i][w] != l1_pkg::AGE_MAX) begin
                    ages_q[set_i][w] <= ages_q[set_i][w] + l1_pkg::age_t'(1);
                end
                // Else hold at AGE_MAX
            end
        end
    end

endmodule

// ==== logic/l1_cache.sv ====
`timescale 1ns/10ps

// 4-way set-associative L1 data cache, one word per line
// Combinational lookup, fill and write-through on the next edge
module l1_cache (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      req_i,       // Access this cycle
    input  logic                      wr_en_i,     // Store when high
    input  logic [l1_pkg::ADDR_W-1:0] addr_i,
    input  logic [l1_pkg::DATA_W-1:0] wr_data_i,
    input  logic [l1_pkg::BE_W-1:0]   byte_en_i,   // Byte, half or word
    output logic [l1_pkg::DATA_W-1:0] rd_data_o,
    output logic                      hit_o,
    mem_port_if.cache                 mem          // To backing RAM
);

    // Line storage
    logic [l1_pkg::TAG_W-1:0]    tag_q   [l1_pkg::NUM_SETS][l1_pkg::NUM_WAYS];
    logic [l1_pkg::DATA_W-1:0]   data_q  [l1_pkg::NUM_SETS][l1_pkg::NUM_WAYS];
    logic [l1_pkg::NUM_WAYS-1:0] valid_q [l1_pkg::NUM_SETS];

    // Address split
    logic [l1_pkg::TAG_W-1:0]   tag;
    logic [l1_pkg::INDEX_W-1:0] set_idx;

    logic                      legal;        // Request with a legal size
    logic                      any_hit;      // Some valid way matches
    l1_pkg::way_t              hit_way;
    l1_pkg::way_t              victim_way;   // From age tracker
    l1_pkg::way_t              fill_way;     // Way written and touched
    logic [l1_pkg::DATA_W-1:0] line_word;    // Current word for this address
    logic [l1_pkg::DATA_W-1:0] lane_mask;    // Byte enables spread to bits
    logic [l1_pkg::DATA_W-1:0] merged_word;  // line_word with store bytes

    assign tag     = addr_i[l1_pkg::ADDR_W-1 -: l1_pkg::TAG_W];      // 31:10
    assign set_idx = addr_i[l1_pkg::OFFSET_W +: l1_pkg::INDEX_W];    // 9:2

    // Size check
    always_comb begin
        case (byte_en_i)
            l1_pkg::BE_BYTE,
            l1_pkg::BE_HALF,
            l1_pkg::BE_WORD: legal = req_i;
            default:         legal = 1'b0;   // Access ignored
        endcase
    end

    // Tag compare, first matching way wins
    always_comb begin
        any_hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < l1_pkg::NUM_WAYS; w++) begin
            if (!any_hit && valid_q[set_idx][w] && tag_q[set_idx][w] == tag) begin
                any_hit = 1'b1;
                hit_way = l1_pkg::way_t'(w);
            end
        end
    end

    // Hit way data, or RAM word on a miss
    assign line_word = any_hit ? data_q[set_idx][hit_way] : mem.rd_data;
    assign fill_way  = any_hit ? hit_way : victim_way;

    always_comb begin
        for (int b = 0; b < l1_pkg::BE_W; b++) begin
            lane_mask[8*b +: 8] = {8{byte_en_i[b]}};
        end
    end

    assign merged_word = (line_word & ~lane_mask) | (wr_data_i & lane_mask);

    // Sized read, zero-extended
    always_comb begin
        rd_data_o = '0;
        if (legal && !wr_en_i) begin
            case (byte_en_i)
                l1_pkg::BE_BYTE: rd_data_o = {{(l1_pkg::DATA_W-8){1'b0}}, line_word[7:0]};
                l1_pkg::BE_HALF: rd_data_o = {{(l1_pkg::DATA_W-16){1'b0}}, line_word[15:0]};
                default:         rd_data_o = line_word;   // Full word
            endcase
        end
    end

    assign hit_o = legal && any_hit;

    // Write-through path, RAM merges the same lanes
    assign mem.addr      = addr_i;
    assign mem.wr_en     = legal && wr_en_i;
    assign mem.byte_mask = byte_en_i;
    assign mem.wr_data   = wr_data_i;

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int s = 0; s < l1_pkg::NUM_SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (legal && !any_hit) begin
            valid_q[set_idx][victim_way] <= 1'b1;   // Allocate on any miss
        end
    end

    // Tag and data update
    always_ff @(posedge clk) begin
        if (legal) begin
            if (!any_hit) begin
                tag_q[set_idx][victim_way] <= tag;
            end
            // Miss fill or write hit, read hits leave data alone
            if (wr_en_i || !any_hit) begin
                data_q[set_idx][fill_way] <= wr_en_i ? merged_word : line_word;
            end
        end
    end

    // Replacement state
    way_age_tracker i_age_tracker (
        .clk         (clk),
        .reset_i     (reset_i),
        .set_i       (set_idx),
        .touch_i     (legal),       // Every legal access uses a way
        .touch_way_i (fill_way),
        .victim_o    (victim_way)
    );

endmodule

// ==== logic/backing_ram.sv ====
`timescale 1ns/10ps

// Main memory behind the cache
// Word addressed from addr 15:2, upper bits ignored
module backing_ram (
    input  logic    clk,
    mem_port_if.ram mem
);

    logic [l1_pkg::DATA_W-1:0] mem_q [l1_pkg::RAM_WORDS];

    logic [l1_pkg::RAM_AW-1:0] word_idx;

    assign word_idx = mem.addr[l1_pkg::OFFSET_W +: l1_pkg::RAM_AW];

    // Memory comes up all zeros
    initial begin
        for (int i = 0; i < l1_pkg::RAM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // Asynchronous read, old value during a write cycle
    assign mem.rd_data = mem_q[word_idx];

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            for (int b = 0; b < l1_pkg::BE_W; b++) begin
                if (mem.byte_mask[b]) begin
                    mem_q[word_idx][8*b +: 8] <= mem.wr_data[8*b +: 8];   // Lane b
                end
            end
        end
    end

endmodule

// ==== logic/mem_subsys.sv ====
`timescale 1ns/10ps

// Load/store memory subsystem
// L1 data cache in front of a write-through backing RAM
module mem_subsys (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      req_i,       // One access per cycle
    input  logic                      wr_en_i,
    input  logic [l1_pkg::ADDR_W-1:0] addr_i,
    input  logic [l1_pkg::DATA_W-1:0] wr_data_i,
    input  logic [l1_pkg::BE_W-1:0]   byte_en_i,
    output logic [l1_pkg::DATA_W-1:0] rd_data_o,   // Same cycle as req_i
    output logic                      hit_o
);

    // Cache to RAM link
    mem_port_if i_mem_if ();

    // Front end, lookup and fill
    l1_cache i_l1_cache (
        .clk       (clk),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .wr_en_i   (wr_en_i),
        .addr_i    (addr_i),
        .wr_data_i (wr_data_i),
        .byte_en_i (byte_en_i),
        .rd_data_o (rd_data_o),
        .hit_o     (hit_o),
        .mem       (i_mem_if.cache)
    );

    // Backing store
    backing_ram i_backing_ram (
        .clk (clk),
        .mem (i_mem_if.ram)
    );

endmodule

// ==== bench/mem_subsys_assert.sv ====
`timescale 1ns/10ps

// Port-level rules of the memory subsystem, bound into mem_subsys
module mem_subsys_assert (
    input logic                      clk,
    input logic                      reset_i,
    input logic                      req_i,
    input logic                      wr_en_i,
    input logic [l1_pkg::BE_W-1:0]   byte_en_i,
    input logic [l1_pkg::DATA_W-1:0] rd_data_o,
    input logic                      hit_o
);

    logic legal_be;   // One of the three access sizes

    assign legal_be = (byte_en_i == l1_pkg::BE_BYTE) || (byte_en_i == l1_pkg::BE_HALF)
                   || (byte_en_i == l1_pkg::BE_WORD);

    hit_needs_req: assert property (@(posedge clk) disable iff (reset_i) hit_o |-> req_i)
        else $error("hit_o high without a request");

    // Illegal size is a no-op on the outputs
    illegal_quiet: assert property (@(posedge clk) disable iff (reset_i)
        (req_i && !legal_be) |-> (!hit_o && rd_data_o == '0))
        else $error("Output activity on an illegal byte enable");

    idle_or_write_zero: assert property (@(posedge clk) disable iff (reset_i)
        (!req_i || wr_en_i) |-> (rd_data_o == '0))
        else $error("rd_data_o nonzero on idle cycle or write");

    outputs_known: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown({hit_o, rd_data_o}))
        else $error("Unknown value on hit_o or rd_data_o");

endmodule

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/10ps

// Random load/store traffic against a flat RAM plus age-based cache model
module tb_mem_subsys;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_OPS    = 4000;
    localparam int RESET_AT   = 2500;                 // Mid-run reset point
    localparam int NUM_IDX    = 3;                    // Few sets so evictions are frequent
    localparam int NUM_TAGS   = 6;
    localparam int TIMEOUT_NS = (NUM_OPS + 50) * CLK_PERIOD * 2;

    localparam logic [l1_pkg::INDEX_W-1:0] IDX_STEP = 8'd85;   // Spreads the pool sets apart

    logic                      clk;
    logic                      reset_i;
    logic                      req_i;
    logic                      wr_en_i;
    logic [l1_pkg::ADDR_W-1:0] addr_i;
    logic [l1_pkg::DATA_W-1:0] wr_data_i;
    logic [l1_pkg::BE_W-1:0]   byte_en_i;
    logic [l1_pkg::DATA_W-1:0] rd_data_o;
    logic                      hit_o;

    integer seed = 32'h1e40ab39;
    int     fail_count;

    // Model state
    logic [l1_pkg::DATA_W-1:0]  ram_model   [l1_pkg::RAM_WORDS];
    logic [l1_pkg::TAG_W-1:0]   tag_model   [l1_pkg::NUM_SETS][l1_pkg::NUM_WAYS];
    logic                       valid_model [l1_pkg::NUM_SETS][l1_pkg::NUM_WAYS];
    l1_pkg::age_t               age_model   [l1_pkg::NUM_SETS][l1_pkg::NUM_WAYS];
    logic [l1_pkg::INDEX_W-1:0] idx_pool    [NUM_IDX];
    logic [l1_pkg::TAG_W-1:0]   tag_pool    [NUM_TAGS];

    mem_subsys i_mem_subsys (.*);

    bind mem_subsys mem_subsys_assert i_mem_subsys_assert (
        .clk       (clk),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .wr_en_i   (wr_en_i),
        .byte_en_i (byte_en_i),
        .rd_data_o (rd_data_o),
        .hit_o     (hit_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_count++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    function automatic logic is_legal(input logic [l1_pkg::BE_W-1:0] be);
        return be == l1_pkg::BE_BYTE || be == l1_pkg::BE_HALF || be == l1_pkg::BE_WORD;
    endfunction

    // Low lanes zero-extended
    function automatic logic [31:0] size_cut(input logic [31:0] word,
                                             input logic [l1_pkg::BE_W-1:0] be);
        if (be == l1_pkg::BE_BYTE) return {24'd0, word[7:0]};
        if (be == l1_pkg::BE_HALF) return {16'd0, word[15:0]};
        return word;
    endfunction

    task automatic clear_cache_model();
        for (int s = 0; s < l1_pkg::NUM_SETS; s++) begin
            for (int w = 0; w < l1_pkg::NUM_WAYS; w++) begin
                valid_model[s][w] = 1'b0;
                age_model[s][w]   = '0;
            end
        end
    endtask

    // Oldest way with ties going to the lowest index
    function automatic l1_pkg::way_t pick_victim(input logic [l1_pkg::INDEX_W-1:0] s);
        l1_pkg::way_t v;
        l1_pkg::age_t best;
        v    = '0;
        best = age_model[s][0];
        for (int w = 1; w < l1_pkg::NUM_WAYS; w++) begin
            if (age_model[s][w] > best) begin
                best = age_model[s][w];
                v    = l1_pkg::way_t'(w);
            end
        end
        return v;
    endfunction

    task automatic touch_way(input logic [l1_pkg::INDEX_W-1:0] s, input l1_pkg::way_t way);
        for (int w = 0; w < l1_pkg::NUM_WAYS; w++) begin
            if (l1_pkg::way_t'(w) == way) begin
                age_model[s][w] = '0;
            end else if (age_model[s][w] != l1_pkg::AGE_MAX) begin
                age_model[s][w] = age_model[s][w] + 2'd1;
            end
        end
    endtask

    // One random access checked at mid-cycle before the model steps ahead
    task automatic run_access();
        logic [31:0]                r_ctl;
        logic [31:0]                r_adr;
        logic [l1_pkg::DATA_W-1:0]  wdata;
        logic [l1_pkg::ADDR_W-1:0]  addr;
        logic [l1_pkg::BE_W-1:0]    be;
        logic [l1_pkg::INDEX_W-1:0] s;
        logic [l1_pkg::TAG_W-1:0]   t;
        logic [l1_pkg::RAM_AW-1:0]  w_idx;
        logic                       do_req;
        logic                       do_wr;
        logic                       legal;
        logic                       hit;
        l1_pkg::way_t               way;
        r_ctl  = $random(seed);
        r_adr  = $random(seed);
        wdata  = $random(seed);
        do_req = (r_ctl[3:0] != 4'd0);                  // About 1 in 16 idle
        do_wr  = r_ctl[4];
        case (r_ctl[6:5])
            2'd0:    be = l1_pkg::BE_BYTE;
            2'd1:    be = l1_pkg::BE_HALF;
            default: be = l1_pkg::BE_WORD;
        endcase
        if (r_ctl[11:7] < 5'd2) begin                   // Illegal size now and then
            be = r_ctl[15:12];
            if (is_legal(be)) be = 4'b0110;
        end
        addr = {tag_pool[int'(r_adr[7:0]) % NUM_TAGS], idx_pool[int'(r_adr[15:8]) % NUM_IDX],
                r_adr[17:16]};
        @(posedge clk);
        req_i     <= do_req;
        wr_en_i   <= do_wr;
        addr_i    <= addr;
        wr_data_i <= wdata;
        byte_en_i <= be;
        @(negedge clk);
        s     = addr[l1_pkg::OFFSET_W +: l1_pkg::INDEX_W];
        t     = addr[l1_pkg::ADDR_W-1 -: l1_pkg::TAG_W];
        w_idx = addr[l1_pkg::OFFSET_W +: l1_pkg::RAM_AW];
        legal = do_req && is_legal(be);
        hit   = 1'b0;
        way   = '0;
        for (int w = 0; w < l1_pkg::NUM_WAYS; w++) begin
            if (!hit && valid_model[s][w] && tag_model[s][w] == t) begin
                hit = 1'b1;
                way = l1_pkg::way_t'(w);
            end
        end
        check_value("hit_o", {31'd0, hit_o}, {31'd0, legal && hit});
        check_value("rd_data_o", rd_data_o,
                    (legal && !do_wr) ? size_cut(ram_model[w_idx], be) : 32'd0);
        if (legal) begin
            if (!hit) begin                             // Allocate on any miss
                way = pick_victim(s);
                tag_model[s][way]   = t;
                valid_model[s][way] = 1'b1;
            end
            touch_way(s, way);
            for (int b = 0; b < l1_pkg::BE_W; b++) begin
                if (do_wr && be[b]) ram_model[w_idx][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_i <= 1'b1;
        req_i   <= 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        clear_cache_model();                            // RAM keeps its contents
    endtask

    initial begin
        logic [31:0] r;
        logic [5:0]  low_tag;
        fail_count = 0;
        reset_i    = 1'b1;
        req_i      = 1'b0;
        wr_en_i    = 1'b0;
        addr_i     = '0;
        wr_data_i  = '0;
        byte_en_i  = '0;
        for (int i = 0; i < l1_pkg::RAM_WORDS; i++) ram_model[i] = '0;
        clear_cache_model();
        // Distinct sets and tags whose RAM bits 15:10 differ so no two alias
        r        = $random(seed);
        low_tag  = r[5:0];
        idx_pool[0] = r[15:8];
        for (int i = 1; i < NUM_IDX; i++) idx_pool[i] = idx_pool[i-1] + IDX_STEP;
        for (int i = 0; i < NUM_TAGS; i++) begin
            r           = $random(seed);
            tag_pool[i] = {r[l1_pkg::TAG_W-1:6], low_tag};
            low_tag     = low_tag + 6'd9;
        end
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        for (int n = 0; n < NUM_OPS; n++) begin
            if (n == RESET_AT) apply_reset();
            run_access();
        end
        if (fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== mem_subsys.f ====
logic/l1_pkg.sv
logic/mem_port_if.sv
logic/way_age_tracker.sv
logic/l1_cache.sv
logic/backing_ram.sv
logic/mem_subsys.sv
bench/mem_subsys_assert.sv
bench/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator simulation of the memory subsystem testbench
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run into $(LOG), check for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed, see $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
